/* files.f */
design/qTablePkg.sv
design/neighborStageIf.sv
design/neighborTable.sv
design/neighborSearch.sv
design/neighborWrite.sv
design/clusterHeadUpdate.sv
design/qTableUpdate.sv
sim/qTableUpdate_props.sv
sim/qTableUpdateTb.sv

/* Makefile */
TOP = qTableUpdateTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* sim/qTableUpdateTb.sv */
module qTableUpdateTb import qTablePkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int TableDepth = 4;
    localparam int ChDepth    = 3;
    localparam int NumRows    = 8;
    localparam int RdW        = $clog2(TableDepth);
    localparam int ChRdW      = $clog2(ChDepth);
    // per row: worst-case latency, full readback of both tables, settle window
    localparam int RowCycles  = 2*TableDepth + 2*ChDepth + 10 + 2*(TableDepth + ChDepth) + 4;
    localparam int CycleLimit = 4 + NumRows*RowCycles + 10;

    logic                            clk = 1'b0;
    logic                            nrst;
    logic                            en;
    wordT                            fSourceId, fSourceHops, fClusterId;
    wordT                            fEnergyLeft, fQValue, fKnownCh;
    logic [RdW-1:0]                  rdIndex;
    logic [ChRdW-1:0]                chRdIndex;
    logic                            busy, done;
    logic [$clog2(TableDepth+1)-1:0] neighborCount;
    logic [$clog2(ChDepth+1)-1:0]    knownChCount;
    wordT                            rdSourceId, rdHops, rdClusterId, rdEnergy, rdQValue;
    wordT                            chRdId;

    // stimulus table, counts expected after done
    string rowName [NumRows] = '{"addFirst", "addBusyEn", "addThird", "addFourth",
                                 "updateKnown", "tableFull", "updateBusyEn", "chRepeat"};
    wordT  rowSrc [NumRows]  = '{16'h0101, 16'h0202, 16'h0303, 16'h0404,
                                 16'h0202, 16'h0505, 16'h0404, 16'h0101};
    wordT  rowCh [NumRows]   = '{16'h00a1, 16'h00a1, 16'h00a2, 16'h00a3,
                                 16'h00a2, 16'h00a4, 16'h00a4, 16'h00a1};
    int    rowExpN [NumRows]  = '{1, 2, 3, 4, 4, 4, 4, 4};
    int    rowExpCh [NumRows] = '{1, 1, 2, 3, 3, 3, 3, 3};
    bit    rowPulse [NumRows] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    neighborRecordT model [TableDepth];  // expected table contents
    wordT           chModel [ChDepth];   // expected cluster-head list
    int             modelCount   = 0;
    int             chModelCount = 0;
    int             errors       = 0;
    int             checks       = 0;
    int             doneCount    = 0;
    int             cycles       = 0;

    qTableUpdate #(.TableDepth(TableDepth), .ChDepth(ChDepth)) dut0 (.*);

    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        if (done) doneCount <= doneCount + 1;  // every pulse, stray ones too
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CycleLimit) begin
            $display("timeout: DUT did not finish within %0d cycles", CycleLimit);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic checkValue(input string what, input wordT expected, input wordT actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    // one packet, optional en pulse while busy, then wait for done
    task automatic sendPacket(input neighborRecordT pkt, input wordT ch, input bit pulse);
        @(posedge clk);
        en          <= 1'b1;
        fSourceId   <= pkt.sourceId;
        fSourceHops <= pkt.hops;
        fClusterId  <= pkt.clusterId;
        fEnergyLeft <= pkt.energy;
        fQValue     <= pkt.qValue;
        fKnownCh    <= ch;
        @(posedge clk);
        en <= 1'b0;  // captured on this edge
        if (pulse) begin
            @(posedge clk);
            en         <= 1'b1;  // must be ignored
            fSourceId  <= 16'h0909;
            fClusterId <= 16'hdead;
            fKnownCh   <= 16'h00b9;
            @(posedge clk);
            en <= 1'b0;
        end
        @(negedge clk);
        while (!done) @(negedge clk);
        repeat (3) @(negedge clk);  // room for a second done
    endtask

    // add-or-update, then lookup-then-add on the CH list
    task automatic updateModel(input neighborRecordT pkt, input wordT ch);
        int  slot;
        bit  chKnown;
        slot    = -1;
        chKnown = 1'b0;
        for (int i = 0; i < modelCount; i++) begin
            if (model[i].sourceId == pkt.sourceId) slot = i;
        end
        if (slot >= 0) begin
            model[slot].clusterId = pkt.clusterId;  // hops stay
            model[slot].energy    = pkt.energy;
            model[slot].qValue    = pkt.qValue;
        end else if (modelCount < TableDepth) begin
            model[modelCount] = pkt;
            modelCount++;
        end
        for (int i = 0; i < chModelCount; i++) begin
            if (chModel[i] == ch) chKnown = 1'b1;
        end
        if (!chKnown && chModelCount < ChDepth) begin
            chModel[chModelCount] = ch;
            chModelCount++;
        end
    endtask

    task automatic checkRow(input int r);
        checkValue({rowName[r], " doneCount"}, wordT'(r + 1), wordT'(doneCount));
        checkValue({rowName[r], " busy"}, 16'h0, wordT'(busy));
        checkValue({rowName[r], " neighborCount"}, wordT'(rowExpN[r]), wordT'(neighborCount));
        checkValue({rowName[r], " knownChCount"}, wordT'(rowExpCh[r]), wordT'(knownChCount));
        for (int i = 0; i < modelCount; i++) begin
            @(posedge clk);
            rdIndex <= RdW'(i);
            @(posedge clk);
            @(negedge clk);  // registered read settled
            checkValue($sformatf("%s rdSourceId[%0d]", rowName[r], i), model[i].sourceId,
                       rdSourceId);
            checkValue($sformatf("%s rdHops[%0d]", rowName[r], i), model[i].hops, rdHops);
            checkValue($sformatf("%s rdClusterId[%0d]", rowName[r], i), model[i].clusterId,
                       rdClusterId);
            checkValue($sformatf("%s rdEnergy[%0d]", rowName[r], i), model[i].energy, rdEnergy);
            checkValue($sformatf("%s rdQValue[%0d]", rowName[r], i), model[i].qValue, rdQValue);
        end
        for (int i = 0; i < chModelCount; i++) begin
            @(posedge clk);
            chRdIndex <= ChRdW'(i);
            @(posedge clk);
            @(negedge clk);
            checkValue($sformatf("%s chRdId[%0d]", rowName[r], i), chModel[i], chRdId);
        end
    endtask

    initial begin
        neighborRecordT pkt;
        void'($urandom(88555));
        nrst        <= 1'b0;
        en          <= 1'b0;
        fSourceId   <= '0;
        fSourceHops <= '0;
        fClusterId  <= '0;
        fEnergyLeft <= '0;
        fQValue     <= '0;
        fKnownCh    <= '0;
        rdIndex     <= '0;
        chRdIndex   <= '0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
        for (int r = 0; r < NumRows; r++) begin
            pkt.sourceId  = rowSrc[r];
            pkt.hops      = wordT'($urandom());  // random payload
            pkt.clusterId = wordT'($urandom());
            pkt.energy    = wordT'($urandom());
            pkt.qValue    = wordT'($urandom());
            sendPacket(pkt, rowCh[r], rowPulse[r]);
            updateModel(pkt, rowCh[r]);
            checkRow(r);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sim/qTableUpdate_props.sv */
module qTableUpdate_props #(
    parameter  int TableDepth   = 16,
    parameter  int ChDepth      = 8,
    localparam int CountWidth   = $clog2(TableDepth + 1),
    localparam int ChCountWidth = $clog2(ChDepth + 1)
) (
    input logic                    clk,
    input logic                    nrst,
    input logic                    busy,
    input logic                    done,
    input logic [CountWidth-1:0]   neighborCount,
    input logic [ChCountWidth-1:0] knownChCount
);

    timeunit 1ns;
    timeprecision 1ns;

    // done is a single-cycle pulse
    doneOneCycle: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
        else $error("done held high for two cycles");

    // busy already drops in the done cycle, so look one cycle back
    doneWhileBusy: assert property (@(posedge clk) disable iff (!nrst) $rose(done) |-> $past(busy))
        else $error("done rose without a packet in flight");

    countLimit: assert property (@(posedge clk) disable iff (!nrst)
        neighborCount <= CountWidth'(TableDepth))
        else $error("neighborCount above table depth");

    // full list never grows or wraps
    chCountLimit: assert property (@(posedge clk) disable iff (!nrst)
        knownChCount >= ChCountWidth'(ChDepth) |=> knownChCount == ChCountWidth'(ChDepth))
        else $error("knownChCount moved past list depth");

endmodule

bind qTableUpdate qTableUpdate_props #(.TableDepth(TableDepth), .ChDepth(ChDepth)) props0 (
    .clk(clk), .nrst(nrst), .busy(busy), .done(done),
    .neighborCount(neighborCount), .knownChCount(knownChCount)
);

/* design/qTableUpdate.sv */
module qTableUpdate import qTablePkg::*; #(
    parameter  int TableDepth   = 16,
    parameter  int ChDepth      = 8,
    localparam int IndexWidth   = $clog2(TableDepth),
    localparam int CountWidth   = $clog2(TableDepth + 1),
    localparam int ChIndexWidth = $clog2(ChDepth),
    localparam int ChCountWidth = $clog2(ChDepth + 1)
) (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    en,          // packet strobe, ignored while busy
    input  wordT                    fSourceId,
    input  wordT                    fSourceHops,
    input  wordT                    fClusterId,
    input  wordT                    fEnergyLeft,
    input  wordT                    fQValue,
    input  wordT                    fKnownCh,
    input  logic [IndexWidth-1:0]   rdIndex,
    input  logic [ChIndexWidth-1:0] chRdIndex,
    output logic                    busy,
    output logic                    done,
    output logic [CountWidth-1:0]   neighborCount,
    output logic [ChCountWidth-1:0] knownChCount,
    output wordT                    rdSourceId,
    output wordT                    rdHops,
    output wordT                    rdClusterId,
    output wordT                    rdEnergy,
    output wordT                    rdQValue,
    output wordT                    chRdId
);

    logic [IndexWidth-1:0] searchIndex;
    neighborRecordT        searchRecord;
    neighborRecordT        rdRecord;
    logic                  wrEn;
    logic [IndexWidth-1:0] wrIndex;
    neighborRecordT        wrRecord;
    logic                  chStart;
    wordT                  chId;

    neighborStageIf #(.TableDepth(TableDepth)) stage0 ();  // search to write

    neighborSearch #(.TableDepth(TableDepth)) search0 (
        .clk(clk), .nrst(nrst), .en(en),
        .fSourceId(fSourceId), .fSourceHops(fSourceHops), .fClusterId(fClusterId),
        .fEnergyLeft(fEnergyLeft), .fQValue(fQValue), .fKnownCh(fKnownCh),
        .neighborCount(neighborCount), .searchRecord(searchRecord), .done(done),
        .busy(busy), .searchIndex(searchIndex), .stage(stage0.source)
    );

    neighborWrite #(.TableDepth(TableDepth)) write0 (
        .clk(clk), .nrst(nrst), .stage(stage0.sink),
        .wrEn(wrEn), .wrIndex(wrIndex), .wrRecord(wrRecord),
        .neighborCount(neighborCount), .chStart(chStart), .chId(chId)
    );

    neighborTable #(.TableDepth(TableDepth)) table0 (
        .clk(clk), .searchIndex(searchIndex), .rdIndex(rdIndex),
        .wrEn(wrEn), .wrIndex(wrIndex), .wrRecord(wrRecord),
        .searchRecord(searchRecord), .rdRecord(rdRecord)
    );

    clusterHeadUpdate #(.ChDepth(ChDepth)) ch0 (
        .clk(clk), .nrst(nrst), .chStart(chStart), .chId(chId),
        .chRdIndex(chRdIndex), .knownChCount(knownChCount),
        .chRdId(chRdId), .done(done)
    );

    // readback fields
    assign rdSourceId  = rdRecord.sourceId;
    assign rdHops      = rdRecord.hops;
    assign rdClusterId = rdRecord.clusterId;
    assign rdEnergy    = rdRecord.energy;
    assign rdQValue    = rdRecord.qValue;

endmodule

/* design/clusterHeadUpdate.sv */
module clusterHeadUpdate import qTablePkg::*; #(
    parameter  int ChDepth      = 8,
    localparam int ChIndexWidth = $clog2(ChDepth),
    localparam int ChCountWidth = $clog2(ChDepth + 1)
) (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    chStart,
    input  wordT                    chId,
    input  logic [ChIndexWidth-1:0] chRdIndex,  // external inspection port
    output logic [ChCountWidth-1:0] knownChCount,
    output wordT                    chRdId,
    output logic                    done
);

    wordT                    chList [ChDepth];  // known cluster heads
    wordT                    scanId;    // list word under compare
    wordT                    newId;     // advertised ID of this packet
    logic [ChCountWidth-1:0] scanIdx;
    chStateT                 state;
    logic                    listWrEn;
    logic                    hasRoom;

    assign hasRoom  = knownChCount < ChCountWidth'(ChDepth);
    assign listWrEn = (state == ChAppend);
    assign done     = (state == ChDone);  // one cycle, state leaves at once

    // list storage
    // entries beyond the count are never compared
    always_ff @(posedge clk) begin
        if (listWrEn) begin
            chList[knownChCount[ChIndexWidth-1:0]] <= newId;  // append at count
        end
    end

    // scan read, ready in ChCompare
    always_ff @(posedge clk) begin
        scanId <= chList[scanIdx[ChIndexWidth-1:0]];
    end

    // external read
    always_ff @(posedge clk) begin
        chRdId <= chList[chRdIndex];
    end

    // lookup then add
    always_ff @(posedge clk) begin
        if (!nrst) begin
            state        <= ChIdle;
            scanIdx      <= '0;
            knownChCount <= '0;
        end else begin
            case (state)
                ChIdle: begin
                    if (chStart) begin
                        newId   <= chId;
                        scanIdx <= '0;
                        state   <= ChRead;
                    end
                end
                ChRead: begin
                    if (scanIdx == knownChCount) begin
                        // end of list, ID is new
                        state <= hasRoom ? ChAppend : ChDone;
                    end else begin
                        state <= ChCompare;
                    end
                end
                ChCompare: begin
                    if (scanId == newId) begin
                        state <= ChDone;  // already known
                    end else begin
                        scanIdx <= scanIdx + 1'b1;
                        state   <= ChRead;
                    end
                end
                ChAppend: begin
                    knownChCount <= knownChCount + 1'b1;
                    state        <= ChDone;
                end
                ChDone:  state <= ChIdle;
                default: state <= ChIdle;
            endcase
        end
    end

endmodule

/* design/neighborWrite.sv */
module neighborWrite import qTablePkg::*; #(
    parameter  int TableDepth = 16,
    localparam int IndexWidth = $clog2(TableDepth),
    localparam int CountWidth = $clog2(TableDepth + 1)
) (
    input  logic                  clk,
    input  logic                  nrst,
    neighborStageIf.sink          stage,
    output logic                  wrEn,
    output logic [IndexWidth-1:0] wrIndex,
    output neighborRecordT        wrRecord,
    output logic [CountWidth-1:0] neighborCount,
    output logic                  chStart,  // kicks off the cluster-head stage
    output wordT                  chId
);

    logic hasRoom;

    assign hasRoom = neighborCount < CountWidth'(TableDepth);

    // control, one cycle after valid
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wrEn          <= 1'b0;
            chStart       <= 1'b0;
            neighborCount <= '0;
        end else begin
            wrEn    <= 1'b0;
            chStart <= 1'b0;
            if (stage.valid) begin
                chStart <= 1'b1;  // every packet goes on to the CH list
                if (stage.found) begin
                    wrEn <= 1'b1;  // overwrite in place
                end else if (hasRoom) begin
                    wrEn          <= 1'b1;  // append at index == count
                    neighborCount <= neighborCount + 1'b1;
                end
                // full and unknown, table untouched
            end
        end
    end

    // payload, captured alongside the control
    always_ff @(posedge clk) begin
        if (stage.valid) begin
            wrIndex  <= stage.index;
            wrRecord <= stage.record;
            chId     <= stage.knownCh;
        end
    end

endmodule

/* design/neighborSearch.sv */
module neighborSearch import qTablePkg::*; #(
    parameter  int TableDepth = 16,
    localparam int IndexWidth = $clog2(TableDepth),
    localparam int CountWidth = $clog2(TableDepth + 1)
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  en,
    input  wordT                  fSourceId,
    input  wordT                  fSourceHops,
    input  wordT                  fClusterId,
    input  wordT                  fEnergyLeft,
    input  wordT                  fQValue,
    input  wordT                  fKnownCh,
    input  logic [CountWidth-1:0] neighborCount,  // scan bound
    input  neighborRecordT        searchRecord,   // table data, one cycle after index
    input  logic                  done,
    output logic                  busy,
    output logic [IndexWidth-1:0] searchIndex,
    neighborStageIf.source        stage
);

    searchStateT           state;
    neighborRecordT        pkt;      // captured packet fields
    neighborRecordT        merged;   // packet with the stored hop count
    logic [CountWidth-1:0] scanIdx;  // wide enough to reach the count
    logic                  accept;

    // busy falls in the done cycle, so a new en may land there
    assign busy        = (state != SearchIdle) && !done;
    assign accept      = en && !busy;
    assign searchIndex = scanIdx[IndexWidth-1:0];

    // update keeps hops, takes the rest from the packet
    always_comb begin
        merged      = pkt;
        merged.hops = searchRecord.hops;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state       <= SearchIdle;
            scanIdx     <= '0;
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= 1'b0;  // strobe
            if (accept) begin
                pkt.sourceId  <= fSourceId;
                pkt.hops      <= fSourceHops;
                pkt.clusterId <= fClusterId;
                pkt.energy    <= fEnergyLeft;
                pkt.qValue    <= fQValue;
                stage.knownCh <= fKnownCh;  // held until the next packet
                scanIdx       <= '0;
                state         <= SearchRead;
            end else begin
                case (state)
                    SearchRead: begin
                        if (scanIdx == neighborCount) begin  // not in table
                            stage.valid  <= 1'b1;
                            stage.found  <= 1'b0;
                            stage.index  <= scanIdx[IndexWidth-1:0];
                            stage.record <= pkt;
                            state        <= SearchWait;
                        end else begin
                            state <= SearchCompare;  // read in flight
                        end
                    end
                    SearchCompare: begin
                        if (searchRecord.sourceId == pkt.sourceId) begin
                            stage.valid  <= 1'b1;
                            stage.found  <= 1'b1;
                            stage.index  <= scanIdx[IndexWidth-1:0];
                            stage.record <= merged;
                            state        <= SearchWait;
                        end else begin
                            scanIdx <= scanIdx + 1'b1;  // next entry
                            state   <= SearchRead;
                        end
                    end
                    SearchWait: begin
                        if (done) begin
                            state <= SearchIdle;
                        end
                    end
                    default: state <= SearchIdle;
                endcase
            end
        end
    end

endmodule

/* design/neighborTable.sv */
module neighborTable import qTablePkg::*; #(
    parameter  int TableDepth = 16,
    localparam int IndexWidth = $clog2(TableDepth)
) (
    input  logic                  clk,
    input  logic [IndexWidth-1:0] searchIndex,  // scan port from search stage
    input  logic [IndexWidth-1:0] rdIndex,      // external inspection port
    input  logic                  wrEn,
    input  logic [IndexWidth-1:0] wrIndex,
    input  neighborRecordT        wrRecord,
    output neighborRecordT        searchRecord,
    output neighborRecordT        rdRecord
);

    // record storage
    // slots at or above neighborCount hold stale data and are never matched
    neighborRecordT mem [TableDepth];

    // single write port, add or update
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIndex] <= wrRecord;
        end
    end

    // scan read, data one cycle after index
    always_ff @(posedge clk) begin
        searchRecord <= mem[searchIndex];
    end

    // external read, same one-cycle latency
    always_ff @(posedge clk) begin
        rdRecord <= mem[rdIndex];
    end

    // read and write never collide on the scan port
    // since the write lands only after the scan has ended

endmodule

/* design/neighborStageIf.sv */
interface neighborStageIf import qTablePkg::*; #(
    parameter int TableDepth = 16
);

    localparam int IndexWidth = $clog2(TableDepth);

    logic                  valid;    // one-cycle strobe per packet
    logic                  found;    // source ID already stored
    logic [IndexWidth-1:0] index;    // match slot, or count for a new entry
    neighborRecordT        record;   // entry to write, hops already merged
    wordT                  knownCh;  // advertised cluster head

    // search stage drives the result
    modport source (
        output valid,
        output found,
        output index,
        output record,
        output knownCh
    );

    // write stage takes it, no back-pressure
    modport sink (
        input valid,
        input found,
        input index,
        input record,
        input knownCh
    );

endinterface

/* design/qTablePkg.sv */
package qTablePkg;

    // field width shared by packet inputs and table words
    localparam int WordWidth = 16;

    typedef logic [WordWidth-1:0] wordT; // one packet or table field

    // one neighbor table entry, 80 bits
    typedef struct packed {
        wordT sourceId;   // neighbor node ID, the search key
        wordT hops;       // hop count, kept on update
        wordT clusterId;  // cluster the neighbor sits in
        wordT energy;     // remaining energy
        wordT qValue;     // route value
    } neighborRecordT;

    // search stage states
    typedef enum logic [1:0] {
        SearchIdle,     // waiting for en
        SearchRead,     // present scan index or stop at count
        SearchCompare,  // stored source ID against packet
        SearchWait      // result handed on, hold until done
    } searchStateT;

    // cluster-head stage states
    typedef enum logic [2:0] {
        ChIdle,     // waiting for chStart
        ChRead,     // present list index or stop at count
        ChCompare,  // stored ID against advertised ID
        ChAppend,   // write new ID at count
        ChDone      // one-cycle done
    } chStateT;

endpackage
